/* ir_filter_cfg.svh */
`ifndef IR_FILTER_CFG_SVH
`define IR_FILTER_CFG_SVH

// Pixel format
`define PIX_W   8   // Bits per colour channel
`define CH_NUM  3   // Channels per pixel

// Image geometry
`define DIM_W   11  // Width and height fields and counters

// APB slave
`define APB_AW  8   // Address bits decoded
`define APB_DW  32

// Register values after reset
`define RST_WIDTH   11'd640
`define RST_HEIGHT  11'd480
`define RST_THR     8'h80

`endif

/* ir_types_pkg.sv */
`include "ir_filter_cfg.svh"

package ir_types_pkg;

  typedef logic [`PIX_W-1:0] chan_t;              // One colour channel

  typedef logic [`DIM_W-1:0] dim_t;               // Image dimension or coordinate

  typedef logic [`CH_NUM*`PIX_W-1:0] pix_word_t;  // Pixel as seen on tdata

  // Same 24 bits read as a flat word or per channel
  // Channel 0 sits in the low byte
  typedef union packed {
    pix_word_t              raw;
    chan_t [`CH_NUM-1:0]    ch;
  } pixel_t;

endpackage

/* ir_regs_pkg.sv */
`include "ir_filter_cfg.svh"

package ir_regs_pkg;

  // Byte offsets on the APB bus
  typedef enum logic [`APB_AW-1:0] {
    REG_CTRL = 8'h00,  // Bit 0 test mode enable
    REG_SIZE = 8'h04,  // Width 10..0 and height 26..16
    REG_FILT = 8'h08   // Mode 1..0 and threshold 15..8
  } reg_addr_e;

  // Code 3 is not listed and behaves as bypass
  typedef enum logic [1:0] {
    BYPASS = 2'd0,
    THRESH = 2'd1,
    INVERT = 2'd2
  } out_mode_e;

  typedef struct packed {
    logic                 test_mode_en;  // Route the pattern source
    ir_types_pkg::dim_t   img_width;
    ir_types_pkg::dim_t   img_height;
    out_mode_e            out_sel;       // Filter mode
    ir_types_pkg::chan_t  pix_corr_thr;  // Threshold for THRESH mode
  } cfg_t;

endpackage

/* frame_if.sv */
interface frame_if;
  import ir_types_pkg::*;

  logic   val;   // Source has a beat
  logic   rdy;   // Sink takes it
  pixel_t data;
  logic   sof;   // Start of frame
  logic   eof;   // End of frame
  logic   sol;   // Start of line
  logic   eol;   // End of line

  modport src (
    output val, data, sof, eof, sol, eol,
    input  rdy
  );

  modport snk (
    input  val, data, sof, eof, sol, eol,
    output rdy
  );

endinterface

/* apb_regs.sv */
`include "ir_filter_cfg.svh"

module apb_regs (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`APB_AW-1:0]    paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [`APB_DW-1:0]    pwdata,
  output logic [`APB_DW-1:0]    prdata,
  output ir_regs_pkg::cfg_t     cfg
);
  import ir_regs_pkg::*;

  logic wr_en;

  assign wr_en = psel && penable && pwrite;  // Access phase of a write

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg.test_mode_en <= 1'b0;
      cfg.img_width    <= `RST_WIDTH;
      cfg.img_height   <= `RST_HEIGHT;
      cfg.out_sel      <= BYPASS;
      cfg.pix_corr_thr <= `RST_THR;
    end else if (wr_en) begin
      case (paddr)
        REG_CTRL: begin
          cfg.test_mode_en <= pwdata[0];
        end
        REG_SIZE: begin
          cfg.img_width  <= pwdata[`DIM_W-1:0];
          cfg.img_height <= pwdata[16 +: `DIM_W];
        end
        REG_FILT: begin
          cfg.out_sel      <= out_mode_e'(pwdata[1:0]);
          cfg.pix_corr_thr <= pwdata[8 +: `PIX_W];
        end
        default: ;  // Writes to holes are dropped
      endcase
    end
  end

  // Read data needs no strobe since there are no wait states
  always_comb begin
    prdata = '0;
    case (paddr)
      REG_CTRL: begin
        prdata[0] = cfg.test_mode_en;
      end
      REG_SIZE: begin
        prdata[`DIM_W-1:0]   = cfg.img_width;
        prdata[16 +: `DIM_W] = cfg.img_height;
      end
      REG_FILT: begin
        prdata[1:0]          = cfg.out_sel;
        prdata[8 +: `PIX_W]  = cfg.pix_corr_thr;
      end
      default: prdata = '0;
    endcase
  end

  // Bus master must hold psel through the access phase
  a_penable_in_sel : assert property (
    @(posedge clk) disable iff (!arst_n)
    penable |-> psel
  ) else $error("APB penable seen without psel");

endmodule

/* stream_to_frame.sv */
`include "ir_filter_cfg.svh"

module stream_to_frame (
  input  logic                          clk,
  input  logic                          arst_n,
  input  ir_regs_pkg::cfg_t             cfg,
  input  logic [`CH_NUM*`PIX_W-1:0]     s_tdata,
  input  logic                          s_tvalid,
  input  logic                          s_tuser,
  input  logic                          s_tlast,
  output logic                          s_tready,
  frame_if.src                          out
);
  import ir_types_pkg::*;

  dim_t col;
  dim_t row;
  dim_t row_cur;   // Row of the beat on the bus
  dim_t last_col;
  dim_t last_row;
  logic xfer;

  assign last_col = cfg.img_width - 1'b1;
  assign last_row = cfg.img_height - 1'b1;
  assign row_cur  = s_tuser ? '0 : row;  // Frame start restarts rows
  assign xfer     = s_tvalid && out.rdy;

  // Straight through the bus with no storage
  assign s_tready      = out.rdy;
  assign out.val       = s_tvalid;
  assign out.data.raw  = s_tdata;
  assign out.sof       = s_tuser;
  assign out.eol       = s_tlast;
  assign out.sol       = (col == '0);
  assign out.eof       = s_tlast && (row_cur == last_row);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      col <= '0;
      row <= '0;
    end else if (xfer) begin
      if (s_tlast) begin
        col <= '0;
        row <= (row_cur == last_row) ? '0 : row_cur + 1'b1;
      end else begin
        col <= col + 1'b1;
        row <= row_cur;
      end
    end
  end

  // Camera lines must match the programmed width
  a_tlast_at_width : assert property (
    @(posedge clk) disable iff (!arst_n)
    xfer && s_tlast |-> col == last_col
  ) else $error("Line end accepted away from the last column");

endmodule

/* test_pattern_gen.sv */
`include "ir_filter_cfg.svh"

module test_pattern_gen (
  input  logic               clk,
  input  logic               arst_n,
  input  ir_regs_pkg::cfg_t  cfg,
  frame_if.src               out
);
  import ir_types_pkg::*;

  dim_t col;
  dim_t row;
  dim_t last_col;
  dim_t last_row;
  dim_t col_x_row;
  logic mid_frame;
  logic line_end;
  logic frame_end;
  logic xfer;

  assign last_col  = cfg.img_width - 1'b1;
  assign last_row  = cfg.img_height - 1'b1;
  assign col_x_row = col ^ row;
  assign mid_frame = (col != '0) || (row != '0);

  // Compare with >= so a size change during a frame still wraps
  assign line_end  = (col >= last_col);
  assign frame_end = line_end && (row >= last_row);

  // A started frame is finished even after test mode drops
  // so the selector always sees its end of frame
  assign out.val = cfg.test_mode_en || mid_frame;
  assign xfer    = out.val && out.rdy;

  assign out.sof = !mid_frame;
  assign out.sol = (col == '0);
  assign out.eol = line_end;
  assign out.eof = frame_end;

  always_comb begin
    out.data.ch[0] = col[`PIX_W-1:0];
    out.data.ch[1] = row[`PIX_W-1:0];
    out.data.ch[2] = col_x_row[`PIX_W-1:0];
  end

  // Counters rest at zero once test mode is off
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      col <= '0;
      row <= '0;
    end else if (xfer) begin
      if (line_end) begin
        col <= '0;
        row <= frame_end ? '0 : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

endmodule

/* frame_selector.sv */
module frame_selector (
  input  logic               clk,
  input  logic               arst_n,
  input  ir_regs_pkg::cfg_t  cfg,
  frame_if.snk               cam,
  frame_if.snk               pat,
  frame_if.src               out
);

  logic sel_q;       // High routes the pattern source
  logic frame_open;
  logic xfer;

  assign xfer = out.val && out.rdy;

  assign out.val  = sel_q ? pat.val  : cam.val;
  assign out.data = sel_q ? pat.data : cam.data;
  assign out.sof  = sel_q ? pat.sof  : cam.sof;
  assign out.eof  = sel_q ? pat.eof  : cam.eof;
  assign out.sol  = sel_q ? pat.sol  : cam.sol;
  assign out.eol  = sel_q ? pat.eol  : cam.eol;

  // Idle source is stalled
  assign cam.rdy = !sel_q && out.rdy;
  assign pat.rdy = sel_q && out.rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_q      <= 1'b0;
      frame_open <= 1'b0;
    end else begin
      if (xfer && out.eof) begin
        frame_open <= 1'b0;
      end else if (xfer && out.sof) begin
        frame_open <= 1'b1;
      end
      // A frame opening this cycle keeps its source
      if (!frame_open && !(xfer && out.sof)) begin
        sel_q <= cfg.test_mode_en;
      end
    end
  end

  // Any beat short of the frame end keeps the source in place
  a_sel_stable_in_frame : assert property (
    @(posedge clk) disable iff (!arst_n)
    xfer && !out.eof |=> $stable(sel_q)
  ) else $error("Source switched in the middle of a frame");

endmodule

/* pixel_filter.sv */
`include "ir_filter_cfg.svh"

module pixel_filter (
  input  logic                          clk,
  input  logic                          arst_n,
  input  ir_regs_pkg::cfg_t             cfg,
  frame_if.snk                          in,
  output logic [`CH_NUM*`PIX_W-1:0]     m_tdata,
  output logic                          m_tvalid,
  output logic                          m_tuser,
  output logic                          m_tlast,
  input  logic                          m_tready
);
  import ir_types_pkg::*;
  import ir_regs_pkg::*;

  pixel_t filt_pix;
  logic   load;

  function automatic chan_t corr_chan(chan_t c, out_mode_e mode, chan_t thr);
    chan_t res;
    case (mode)
      THRESH:  res = (c >= thr) ? '1 : '0;
      INVERT:  res = ~c;  // Equals full scale minus c
      default: res = c;
    endcase
    return res;
  endfunction

  always_comb begin
    for (int i = 0; i < `CH_NUM; i++) begin
      filt_pix.ch[i] = corr_chan(in.data.ch[i], cfg.out_sel, cfg.pix_corr_thr);
    end
  end

  assign in.rdy = !m_tvalid || m_tready;  // Empty or draining
  assign load   = in.val && in.rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_tvalid <= 1'b0;
    end else if (load) begin
      m_tvalid <= 1'b1;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      m_tdata <= filt_pix.raw;
      m_tuser <= in.sof;
      m_tlast <= in.eol;
    end
  end

  // Frame start must fall on a line start
  a_markers_consistent : assert property (
    @(posedge clk) disable iff (!arst_n)
    in.val |-> !in.sof || in.sol
  ) else $error("Frame marker without matching line marker");

  a_hold_under_stall : assert property (
    @(posedge clk) disable iff (!arst_n)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata)
  ) else $error("Output beat changed while stalled");

endmodule

/* ir_filter_top.sv */
`include "ir_filter_cfg.svh"

module ir_filter_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [`APB_AW-1:0]            paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [`APB_DW-1:0]            pwdata,
  output logic [`APB_DW-1:0]            prdata,
  input  logic [`CH_NUM*`PIX_W-1:0]     s_tdata,
  input  logic                          s_tvalid,
  input  logic                          s_tuser,   // Start of frame
  input  logic                          s_tlast,   // End of line
  output logic                          s_tready,
  output logic [`CH_NUM*`PIX_W-1:0]     m_tdata,
  output logic                          m_tvalid,
  output logic                          m_tuser,
  output logic                          m_tlast,
  input  logic                          m_tready
);
  import ir_regs_pkg::*;

  cfg_t cfg;

  frame_if cam_bus ();  // Camera stream
  frame_if pat_bus ();  // Test pattern
  frame_if sel_bus ();  // Into the filter

  apb_regs i_apb_regs (
    .clk     (clk     ),
    .arst_n  (arst_n  ),
    .paddr   (paddr   ),
    .psel    (psel    ),
    .penable (penable ),
    .pwrite  (pwrite  ),
    .pwdata  (pwdata  ),
    .prdata  (prdata  ),
    .cfg     (cfg     )
  );

  stream_to_frame i_stream_to_frame (
    .clk      (clk     ),
    .arst_n   (arst_n  ),
    .cfg      (cfg     ),
    .s_tdata  (s_tdata ),
    .s_tvalid (s_tvalid),
    .s_tuser  (s_tuser ),
    .s_tlast  (s_tlast ),
    .s_tready (s_tready),
    .out      (cam_bus )
  );

  test_pattern_gen i_test_pattern_gen (
    .clk    (clk    ),
    .arst_n (arst_n ),
    .cfg    (cfg    ),
    .out    (pat_bus)
  );

  frame_selector i_frame_selector (
    .clk    (clk    ),
    .arst_n (arst_n ),
    .cfg    (cfg    ),
    .cam    (cam_bus),
    .pat    (pat_bus),
    .out    (sel_bus)
  );

  pixel_filter i_pixel_filter (
    .clk      (clk     ),
    .arst_n   (arst_n  ),
    .cfg      (cfg     ),
    .in       (sel_bus ),
    .m_tdata  (m_tdata ),
    .m_tvalid (m_tvalid),
    .m_tuser  (m_tuser ),
    .m_tlast  (m_tlast ),
    .m_tready (m_tready)
  );

endmodule

/* tb_ir_filter_top.sv */
`include "ir_filter_cfg.svh"

module tb_ir_filter_top;
  import ir_types_pkg::*;
  import ir_regs_pkg::*;

  localparam int PIX_BITS  = `CH_NUM * `PIX_W;
  localparam int TOTAL_PIX = 4 * 12 + 10;  // Four 4x3 frames and one 5x2 pattern frame
  localparam int WDOG_TIME = 20 * (4 * TOTAL_PIX + 2000);

  logic                clk;
  logic                arst_n;
  logic [`APB_AW-1:0]  paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [`APB_DW-1:0]  pwdata;
  logic [`APB_DW-1:0]  prdata;
  logic [PIX_BITS-1:0] s_tdata;
  logic                s_tvalid;
  logic                s_tuser;
  logic                s_tlast;
  logic                s_tready;
  logic [PIX_BITS-1:0] m_tdata;
  logic                m_tvalid;
  logic                m_tuser;
  logic                m_tlast;
  logic                m_tready;
  logic                rand_ready;  // Random stalls on m_tready

  logic [PIX_BITS-1:0] exp_data_q[$];
  logic                exp_user_q[$];
  logic                exp_last_q[$];
  logic [PIX_BITS-1:0] got_data_q[$];
  logic                got_user_q[$];
  logic                got_last_q[$];

  ir_filter_top i_ir_filter_top (
    .clk      (clk     ),
    .arst_n   (arst_n  ),
    .paddr    (paddr   ),
    .psel     (psel    ),
    .penable  (penable ),
    .pwrite   (pwrite  ),
    .pwdata   (pwdata  ),
    .prdata   (prdata  ),
    .s_tdata  (s_tdata ),
    .s_tvalid (s_tvalid),
    .s_tuser  (s_tuser ),
    .s_tlast  (s_tlast ),
    .s_tready (s_tready),
    .m_tdata  (m_tdata ),
    .m_tvalid (m_tvalid),
    .m_tuser  (m_tuser ),
    .m_tlast  (m_tlast ),
    .m_tready (m_tready)
  );

  always #10 clk = ~clk;

  // Sink side of the output stream
  initial begin
    m_tready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      m_tready = rand_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
    end
  end

  // Output beats are taken at the next rising edge
  always @(negedge clk) begin
    if (arst_n && m_tvalid && m_tready) begin
      got_data_q.push_back(m_tdata);
      got_user_q.push_back(m_tuser);
      got_last_q.push_back(m_tlast);
    end
  end

  task automatic stop_failed();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic fail_with(input string why);
    $display("%s", why);
    stop_failed();
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic next_drive_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data);
    next_drive_slot();
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    next_drive_slot();
    penable = 1'b1;  // Access phase
    next_drive_slot();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data);
    next_drive_slot();
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    next_drive_slot();
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    next_drive_slot();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic logic [31:0] size_word(input int w, input int h);
    return 32'((h << 16) | w);
  endfunction

  function automatic logic [31:0] filt_word(input out_mode_e mode, input chan_t thr);
    return {16'h0, thr, 6'h0, mode};
  endfunction

  // Channel rule of each filter mode
  function automatic chan_t filtered_chan(input chan_t c, input out_mode_e mode, input chan_t thr);
    if (mode == THRESH) begin
      return (c >= thr) ? 8'hFF : 8'h00;
    end else if (mode == INVERT) begin
      return 8'hFF - c;
    end else begin
      return c;
    end
  endfunction

  task automatic send_frame(input int w, input int h, input out_mode_e mode, input chan_t thr);
    logic [PIX_BITS-1:0] pix;
    logic [PIX_BITS-1:0] exp_pix;
    logic                accepted;
    next_drive_slot();
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < w; c++) begin
        pix = PIX_BITS'($urandom);
        for (int k = 0; k < `CH_NUM; k++) begin
          exp_pix[k*`PIX_W +: `PIX_W] = filtered_chan(pix[k*`PIX_W +: `PIX_W], mode, thr);
        end
        s_tdata  = pix;
        s_tvalid = 1'b1;
        s_tuser  = (r == 0 && c == 0);
        s_tlast  = (c == w - 1);
        exp_data_q.push_back(exp_pix);
        exp_user_q.push_back(r == 0 && c == 0);
        exp_last_q.push_back(c == w - 1);
        accepted = 1'b0;
        while (!accepted) begin
          @(negedge clk);
          accepted = s_tready;
          next_drive_slot();
        end
      end
    end
    s_tvalid = 1'b0;
    s_tuser  = 1'b0;
    s_tlast  = 1'b0;
  endtask

  task automatic compare_beats(input int n, input string what);
    int waited;
    waited = 0;
    while (got_data_q.size() < n && waited < 50 * n) begin
      @(negedge clk);
      waited++;
    end
    for (int i = 0; i < n; i++) begin
      if (got_data_q.size() == 0) begin
        fail_with($sformatf("%s: no output beat arrived where beat %0d was expected", what, i));
      end else begin
        check("m_tdata", 32'(got_data_q.pop_front()), 32'(exp_data_q.pop_front()));
        check("m_tuser", 32'(got_user_q.pop_front()), 32'(exp_user_q.pop_front()));
        check("m_tlast", 32'(got_last_q.pop_front()), 32'(exp_last_q.pop_front()));
      end
    end
  endtask

  task automatic wait_idle();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while (quiet < 4 && waited <= 400) begin
      @(negedge clk);
      quiet = m_tvalid ? 0 : quiet + 1;
      waited++;
    end
    if (quiet < 4) begin
      fail_with("The output stream never went idle");
    end else begin
      next_drive_slot();
    end
  endtask

  task automatic expect_drained(input string what);
    if (got_data_q.size() != 0) begin
      fail_with($sformatf("%s: %0d output beats more than were sent", what, got_data_q.size()));
    end
  endtask

  task automatic flush_outputs();
    got_data_q.delete();
    got_user_q.delete();
    got_last_q.delete();
  endtask

  task automatic reg_access_test();
    logic [31:0] rd;
    apb_read(REG_CTRL, rd);
    check("prdata", rd, 32'h0);
    apb_read(REG_SIZE, rd);
    check("prdata", rd, size_word(640, 480));
    apb_read(REG_FILT, rd);
    check("prdata", rd, filt_word(BYPASS, 8'h80));
    apb_write(REG_SIZE, 32'hFFFF_FFFF);
    apb_read(REG_SIZE, rd);
    check("prdata", rd, 32'h07FF_07FF);  // Only the field bits hold
    apb_write(REG_SIZE, size_word(4, 3));
    apb_read(REG_SIZE, rd);
    check("prdata", rd, size_word(4, 3));
    apb_write(REG_FILT, 32'hFFFF_FFFF);
    apb_read(REG_FILT, rd);
    check("prdata", rd, 32'h0000_FF03);
    apb_write(REG_FILT, filt_word(INVERT, 8'h5A));
    apb_read(REG_FILT, rd);
    check("prdata", rd, filt_word(INVERT, 8'h5A));
    apb_write(REG_CTRL, 32'h1);
    apb_read(REG_CTRL, rd);
    check("prdata", rd, 32'h1);
    apb_write(REG_CTRL, 32'h0);
    apb_read(REG_CTRL, rd);
    check("prdata", rd, 32'h0);
    apb_read(8'h0C, rd);
    check("prdata", rd, 32'h0);
    apb_read(8'hFC, rd);
    check("prdata", rd, 32'h0);
    wait_idle();  // Pattern frame started by test mode drains here
    flush_outputs();
  endtask

  task automatic bypass_frame();
    apb_write(REG_SIZE, size_word(4, 3));
    apb_write(REG_FILT, filt_word(BYPASS, 8'h80));
    send_frame(4, 3, BYPASS, 8'h80);
    compare_beats(12, "bypass");
    wait_idle();
    expect_drained("bypass");
  endtask

  task automatic filter_modes();
    apb_write(REG_FILT, filt_word(THRESH, 8'h60));
    send_frame(4, 3, THRESH, 8'h60);
    compare_beats(12, "threshold");
    wait_idle();
    expect_drained("threshold");
    apb_write(REG_FILT, filt_word(INVERT, 8'h60));
    send_frame(4, 3, INVERT, 8'h60);
    compare_beats(12, "invert");
    wait_idle();
    expect_drained("invert");
  endtask

  task automatic pattern_frame();
    int waited;
    apb_write(REG_FILT, filt_word(BYPASS, 8'h80));
    apb_write(REG_SIZE, size_word(5, 2));
    for (int r = 0; r < 2; r++) begin
      for (int c = 0; c < 5; c++) begin
        exp_data_q.push_back({8'(c ^ r), 8'(r), 8'(c)});
        exp_user_q.push_back(r == 0 && c == 0);
        exp_last_q.push_back(c == 4);
      end
    end
    apb_write(REG_CTRL, 32'h1);
    @(posedge clk);  // Selector picks up test mode here
    waited = 0;
    while (got_data_q.size() < 10 && waited < 500) begin
      @(negedge clk);
      check("s_tready", 32'(s_tready), 32'h0);
      waited++;
    end
    compare_beats(10, "test pattern");
    apb_write(REG_CTRL, 32'h0);
    wait_idle();
    flush_outputs();
  endtask

  task automatic backpressure_frame();
    apb_write(REG_SIZE, size_word(4, 3));
    rand_ready = 1'b1;
    send_frame(4, 3, BYPASS, 8'h80);
    compare_beats(12, "back-pressure");
    rand_ready = 1'b0;
    wait_idle();
    expect_drained("back-pressure");
  endtask

  initial begin
    #(WDOG_TIME);
    fail_with($sformatf("Watchdog expired after %0d time units", WDOG_TIME));
  end

  initial begin
    void'($urandom(94033));
    clk        = 1'b0;
    arst_n     = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    s_tuser    = 1'b0;
    s_tlast    = 1'b0;
    rand_ready = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    check("m_tvalid", 32'(m_tvalid), 32'h0);
    reg_access_test();
    bypass_frame();
    filter_modes();
    pattern_frame();
    backpressure_frame();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* ir_filter_top.f */
+incdir+.
ir_types_pkg.sv
ir_regs_pkg.sv
frame_if.sv
apb_regs.sv
stream_to_frame.sv
test_pattern_gen.sv
frame_selector.sv
pixel_filter.sv
ir_filter_top.sv
tb_ir_filter_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_ir_filter_top \
  -f ir_filter_top.f

output=$(./obj_dir/Vtb_ir_filter_top 2>&1) || true
echo "$output"

if grep -qx '>>> PASS' <<< "$output"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
